//--- hdl/out_fifo_params.svh
`ifndef OUT_FIFO_PARAMS_SVH
`define OUT_FIFO_PARAMS_SVH

// ring size in half-words, kept small for simulation
`define OUT_FIFO_DEPTH 64

// external SRAM address bus
`define OUT_FIFO_AW 20

// threshold register reset values, scaled to 255
`define OUT_FIFO_AF_DEFAULT 8'd242 // ~95 %
`define OUT_FIFO_AE_DEFAULT 8'd12  // ~5 %

`endif

//--- hdl/out_fifo_pkg.sv
`include "out_fifo_params.svh"

package out_fifo_pkg;

    typedef logic [`OUT_FIFO_AW-1:0] sram_addr_t;
    typedef logic [15:0] half_word_t;  // one SRAM location
    typedef logic [31:0] src_word_t;   // upstream word
    typedef logic [20:0] fill_count_t; // half-words held in the ring
    typedef logic [7:0] byte_t;

    // read path: wait for a request, one SRAM read cycle, hand the word over
    typedef enum logic [1:0] {
        rd_idle,
        rd_fetch,
        rd_hold
    } rd_state_t;

endpackage

//--- hdl/fifo_regs.sv
`timescale 1ns/1ps
`include "out_fifo_params.svh"

module fifo_regs import out_fifo_pkg::*; (
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic [15:0] bus_add,
    input  byte_t       bus_data_in,
    input  logic        bus_wr,
    input  logic        bus_rd,
    output byte_t       bus_data_out,
    input  fill_count_t fill_count,
    input  byte_t       read_errors,
    output logic        clear,
    output byte_t       af_thresh,
    output byte_t       ae_thresh
);

    logic soft_rst;

    // write to address 0 gives a one cycle pulse on the next cycle
    always_ff @(posedge BUS_CLK) begin
        if (RST)
            soft_rst <= 1'b0;
        else
            soft_rst <= bus_wr && (bus_add == 16'd0);
    end

    assign clear = RST | soft_rst;

    // threshold registers, back to defaults on any clear
    always_ff @(posedge BUS_CLK) begin
        if (clear) begin
            af_thresh <= `OUT_FIFO_AF_DEFAULT;
            ae_thresh <= `OUT_FIFO_AE_DEFAULT;
        end else if (bus_wr) begin
            if (bus_add == 16'd1)
                af_thresh <= bus_data_in;
            if (bus_add == 16'd2)
                ae_thresh <= bus_data_in;
        end
    end

    // readback, valid the cycle after bus_rd
    always_ff @(posedge BUS_CLK) begin
        if (clear) begin
            bus_data_out <= '0;
        end else if (bus_rd) begin
            case (bus_add)
                16'd1:   bus_data_out <= fill_count[7:0];   // count low byte
                16'd2:   bus_data_out <= fill_count[15:8];
                16'd3:   bus_data_out <= byte_t'(fill_count[20:16]);
                16'd4:   bus_data_out <= read_errors;
                default: bus_data_out <= '0;
            endcase
        end
    end

endmodule

//--- hdl/sram_fifo_ctrl.sv
`timescale 1ns/1ps
`include "out_fifo_params.svh"

module sram_fifo_ctrl import out_fifo_pkg::*; #(
    parameter int DEPTH = `OUT_FIFO_DEPTH
) (
    input  logic        BUS_CLK,
    input  logic        clear,
    input  src_word_t   src_data,
    input  logic        src_empty,
    output logic        src_read,
    output sram_addr_t  sram_a,
    output half_word_t  sram_dq_out,
    output logic        sram_dq_oe,
    input  half_word_t  sram_dq_in,
    output logic        sram_we_b,
    output logic        sram_oe_b,
    input  logic        word_req,
    output logic        word_valid,
    output half_word_t  word_data,
    output logic        fifo_not_empty,
    output logic        fifo_full,
    output fill_count_t fill_count
);

    sram_addr_t wr_ptr;
    sram_addr_t rd_ptr;
    sram_addr_t next_wr_ptr;
    sram_addr_t next_rd_ptr;
    rd_state_t  rd_state;
    logic       empty;
    logic       full;
    logic       start_fetch;
    logic       write_en;
    half_word_t wr_half;

    assign next_wr_ptr = (wr_ptr == sram_addr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    assign next_rd_ptr = (rd_ptr == sram_addr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (next_wr_ptr == rd_ptr); // one slot kept free

    assign start_fetch = (rd_state == rd_idle) && word_req && !empty;

    // read owns the next SRAM cycle; also skip the cycle the source pops
    assign write_en = !src_empty && !full && !start_fetch && !src_read;

    assign wr_half = wr_ptr[0] ? src_data[15:0] : src_data[31:16]; // upper half first

    always_ff @(posedge BUS_CLK) begin
        if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (write_en)
                wr_ptr <= next_wr_ptr;
            if (start_fetch)
                rd_ptr <= next_rd_ptr;
        end
    end

    // SRAM strobes are registered, the cycle after the decision
    always_ff @(posedge BUS_CLK) begin
        if (clear) begin
            sram_we_b  <= 1'b1;
            sram_dq_oe <= 1'b0;
            src_read   <= 1'b0;
        end else begin
            sram_we_b  <= !write_en;
            sram_dq_oe <= write_en;
            src_read   <= write_en && wr_ptr[0]; // pop with the lower half
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (start_fetch)
            sram_a <= rd_ptr;
        else if (write_en)
            sram_a <= wr_ptr;
        if (write_en)
            sram_dq_out <= wr_half;
    end

    always_ff @(posedge BUS_CLK) begin
        if (clear) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle:  if (start_fetch) rd_state <= rd_fetch;
                rd_fetch: rd_state <= rd_hold;
                default:  rd_state <= rd_idle; // holder loads during rd_hold
            endcase
        end
    end

    assign sram_oe_b = (rd_state != rd_fetch);

    always_ff @(posedge BUS_CLK) begin
        if (clear)
            word_valid <= 1'b0;
        else
            word_valid <= (rd_state == rd_fetch);
    end

    always_ff @(posedge BUS_CLK) begin
        if (rd_state == rd_fetch)
            word_data <= sram_dq_in; // sampled at the end of the read cycle
    end

    always_ff @(posedge BUS_CLK) begin
        if (clear)
            fill_count <= '0;
        else if (wr_ptr >= rd_ptr)
            fill_count <= fill_count_t'(wr_ptr - rd_ptr);
        else
            fill_count <= fill_count_t'(wr_ptr) + fill_count_t'(DEPTH) - fill_count_t'(rd_ptr);
    end

    assign fifo_not_empty = !empty;
    assign fifo_full      = full;

endmodule

//--- hdl/usb_byte_out.sv
`timescale 1ns/1ps

module usb_byte_out import out_fifo_pkg::*; (
    input  logic       BUS_CLK,
    input  logic       clear,
    input  logic       word_valid,
    input  half_word_t word_data,
    output logic       word_req,
    input  logic       usb_read,
    output logic       usb_ready,
    output byte_t      usb_data,
    output byte_t      read_errors,
    output logic       fifo_read_error
);

    half_word_t hold;
    logic       hold_full;
    logic       byte_idx; // 0 = upper byte
    logic       consume;

    assign consume = usb_read && hold_full;

    always_ff @(posedge BUS_CLK) begin
        if (clear) begin
            hold_full <= 1'b0;
            byte_idx  <= 1'b0;
        end else if (word_valid) begin
            hold_full <= 1'b1;
            byte_idx  <= 1'b0;
        end else if (consume) begin
            if (byte_idx)
                hold_full <= 1'b0;
            byte_idx <= !byte_idx;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (word_valid)
            hold <= word_data;
    end

    // ask early so the refill overlaps the last byte
    assign word_req = !hold_full || (consume && byte_idx);

    assign usb_ready = hold_full;
    assign usb_data  = byte_idx ? hold[7:0] : hold[15:8];

    always_ff @(posedge BUS_CLK) begin
        if (clear)
            read_errors <= '0;
        else if (usb_read && !hold_full && read_errors != 8'hff)
            read_errors <= read_errors + 1'b1; // saturates
    end

    assign fifo_read_error = (read_errors != '0);

endmodule

//--- hdl/fill_level_flags.sv
`timescale 1ns/1ps
`include "out_fifo_params.svh"

module fill_level_flags import out_fifo_pkg::*; #(
    parameter int DEPTH = `OUT_FIFO_DEPTH
) (
    input  logic        BUS_CLK,
    input  logic        clear,
    input  fill_count_t fill_count,
    input  byte_t       af_thresh,
    input  byte_t       ae_thresh,
    output logic        fifo_near_full
);

    logic [31:0] af_level;
    logic [31:0] ae_level;
    logic [31:0] count;

    // thresholds are in 1/256 steps of the ring
    assign af_level = ((32'(af_thresh) + 32'd1) * 32'(DEPTH)) >> 8;
    assign ae_level = ((32'(ae_thresh) + 32'd1) * 32'(DEPTH)) >> 8;
    assign count    = 32'(fill_count);

    // set wins, then clear, otherwise hold
    always_ff @(posedge BUS_CLK) begin
        if (clear)
            fifo_near_full <= 1'b0;
        else if (count >= af_level || af_thresh == '0)
            fifo_near_full <= 1'b1;
        else if ((count <= ae_level && ae_thresh != '0) || count == '0)
            fifo_near_full <= 1'b0;
    end

endmodule

//--- hdl/out_fifo_top.sv
`timescale 1ns/1ps
`include "out_fifo_params.svh"

module out_fifo_top import out_fifo_pkg::*; #(
    parameter int DEPTH = `OUT_FIFO_DEPTH
) (
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic [15:0] bus_add,
    input  byte_t       bus_data_in,
    input  logic        bus_wr,
    input  logic        bus_rd,
    output byte_t       bus_data_out,

    input  src_word_t   src_data,
    input  logic        src_empty,
    output logic        src_read,

    output sram_addr_t  sram_a,
    output half_word_t  sram_dq_out,
    output logic        sram_dq_oe,
    input  half_word_t  sram_dq_in,
    output logic        sram_we_b,
    output logic        sram_oe_b,

    input  logic        usb_read,
    output logic        usb_ready,
    output byte_t       usb_data,

    output logic        fifo_not_empty,
    output logic        fifo_full,
    output logic        fifo_near_full,
    output logic        fifo_read_error
);

    logic        clear; // RST or soft reset
    byte_t       af_thresh;
    byte_t       ae_thresh;
    byte_t       read_errors;
    fill_count_t fill_count;
    logic        word_req;
    logic        word_valid;
    half_word_t  word_data;

    fifo_regs i_regs (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .fill_count   (fill_count),
        .read_errors  (read_errors),
        .clear        (clear),
        .af_thresh    (af_thresh),
        .ae_thresh    (ae_thresh)
    );

    sram_fifo_ctrl #(.DEPTH(DEPTH)) i_ctrl (
        .BUS_CLK        (BUS_CLK),
        .clear          (clear),
        .src_data       (src_data),
        .src_empty      (src_empty),
        .src_read       (src_read),
        .sram_a         (sram_a),
        .sram_dq_out    (sram_dq_out),
        .sram_dq_oe     (sram_dq_oe),
        .sram_dq_in     (sram_dq_in),
        .sram_we_b      (sram_we_b),
        .sram_oe_b      (sram_oe_b),
        .word_req       (word_req),
        .word_valid     (word_valid),
        .word_data      (word_data),
        .fifo_not_empty (fifo_not_empty),
        .fifo_full      (fifo_full),
        .fill_count     (fill_count)
    );

    usb_byte_out i_usb (
        .BUS_CLK         (BUS_CLK),
        .clear           (clear),
        .word_valid      (word_valid),
        .word_data       (word_data),
        .word_req        (word_req),
        .usb_read        (usb_read),
        .usb_ready       (usb_ready),
        .usb_data        (usb_data),
        .read_errors     (read_errors),
        .fifo_read_error (fifo_read_error)
    );

    fill_level_flags #(.DEPTH(DEPTH)) i_flags (
        .BUS_CLK        (BUS_CLK),
        .clear          (clear),
        .fill_count     (fill_count),
        .af_thresh      (af_thresh),
        .ae_thresh      (ae_thresh),
        .fifo_near_full (fifo_near_full)
    );

endmodule

//--- bench/sram_model.sv
`timescale 1ns/1ps

module sram_model import out_fifo_pkg::*; (
    input  logic       BUS_CLK,
    input  logic       push_en,
    input  src_word_t  push_data,
    input  logic       src_read,
    output logic       src_empty,
    output src_word_t  src_data,
    output int         src_level,
    input  sram_addr_t sram_a,
    input  half_word_t sram_dq_out,
    input  logic       sram_dq_oe,
    input  logic       sram_we_b,
    input  logic       sram_oe_b,
    output half_word_t sram_dq_in
);

    src_word_t  words[$]; // upstream FWFT queue
    half_word_t mem [0:1023];
    half_word_t dq;

    initial begin
        for (int i = 0; i < 1024; i++)
            mem[i] = 16'(i) ^ 16'hc3a5; // power-up junk
    end

    always @(posedge BUS_CLK) begin
        if (src_read && words.size() > 0)
            void'(words.pop_front());
        if (push_en)
            words.push_back(push_data);
        src_empty <= (words.size() == 0);
        if (words.size() > 0)
            src_data <= words[0];
        else
            src_data <= '0;
        src_level <= words.size();
    end

    always @(posedge BUS_CLK) begin
        if (!sram_we_b && sram_dq_oe)
            mem[sram_a[9:0]] <= sram_dq_out;
    end

    // shared data bus, controller drives on writes, SRAM on reads
    assign dq = sram_dq_oe ? sram_dq_out : (!sram_oe_b ? mem[sram_a[9:0]] : 16'h0000);
    assign sram_dq_in = dq;

endmodule

//--- bench/tb_out_fifo.sv
`timescale 1ns/1ps
`include "out_fifo_params.svh"

module tb_out_fifo import out_fifo_pkg::*; ();

    localparam int DEPTH = `OUT_FIFO_DEPTH;
    localparam int MAX_CYCLES = 4000;

    logic        BUS_CLK;
    logic        RST;
    logic [15:0] bus_add;
    byte_t       bus_data_in;
    logic        bus_wr;
    logic        bus_rd;
    byte_t       bus_data_out;
    src_word_t   src_data;
    logic        src_empty;
    logic        src_read;
    sram_addr_t  sram_a;
    half_word_t  sram_dq_out;
    logic        sram_dq_oe;
    half_word_t  sram_dq_in;
    logic        sram_we_b;
    logic        sram_oe_b;
    logic        usb_read;
    logic        usb_ready;
    byte_t       usb_data;
    logic        fifo_not_empty;
    logic        fifo_full;
    logic        fifo_near_full;
    logic        fifo_read_error;
    logic        push_en;
    src_word_t   push_data;
    int          src_level;

    byte_t       exp_q[$];
    int          errors = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'he6116fc1;

    out_fifo_top dut (.*);

    sram_model i_model (
        .BUS_CLK(BUS_CLK), .push_en(push_en), .push_data(push_data),
        .src_read(src_read), .src_empty(src_empty), .src_data(src_data),
        .src_level(src_level), .sram_a(sram_a), .sram_dq_out(sram_dq_out),
        .sram_dq_oe(sram_dq_oe), .sram_we_b(sram_we_b), .sram_oe_b(sram_oe_b),
        .sram_dq_in(sram_dq_in)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #2 BUS_CLK = ~BUS_CLK;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32,22,2,1
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // byte i of a pushed word, most significant first
    function automatic byte_t word_byte(src_word_t w, int i);
        return w[31 - 8 * i -: 8];
    endfunction

    function automatic logic near_full_ref(logic prev, int count, int af, int ae);
        int af_lvl;
        int ae_lvl;
        af_lvl = ((af + 1) * DEPTH) / 256;
        ae_lvl = ((ae + 1) * DEPTH) / 256;
        if (count >= af_lvl || af == 0)
            return 1'b1;
        else if ((count <= ae_lvl && ae != 0) || count == 0)
            return 1'b0;
        return prev;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic fail_note(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic next_cycle();
        @(posedge BUS_CLK);
        #1;
    endtask

    task automatic queue_word(input src_word_t w);
        push_en   = 1'b1;
        push_data = w;
        for (int i = 0; i < 4; i++)
            exp_q.push_back(word_byte(w, i));
    endtask

    task automatic push_words(input int n);
        logic [31:0] w;
        for (int i = 0; i < n; i++) begin
            w = rand_bits(32);
            queue_word(w);
            next_cycle();
        end
        push_en = 1'b0;
    endtask

    task automatic bus_write(input logic [15:0] addr, input byte_t data);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        next_cycle();
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output byte_t data);
        bus_add = addr;
        bus_rd  = 1'b1;
        next_cycle();
        bus_rd = 1'b0;
        data   = bus_data_out;
    endtask

    task automatic read_count(output int count);
        byte_t b0;
        byte_t b1;
        byte_t b2;
        bus_read(16'd1, b0);
        bus_read(16'd2, b1);
        bus_read(16'd3, b2);
        count = {b2, b1, b0};
    endtask

    task automatic settle();
        while (src_level != 0)
            next_cycle();
        repeat (6) next_cycle(); // write, pointer and count latency
    endtask

    task automatic drain();
        while (exp_q.size() > 0) begin
            usb_read = usb_ready;
            next_cycle();
        end
        usb_read = 1'b0;
    endtask

    task automatic take_byte();
        while (!usb_ready)
            next_cycle();
        usb_read = 1'b1;
        next_cycle();
        usb_read = 1'b0;
    endtask

    task automatic soft_reset();
        bus_write(16'd0, 8'h00);
        next_cycle();
        exp_q.delete();
    endtask

    // compare process: every consumed byte against the reference queue
    initial begin
        byte_t exp;
        forever begin
            @(posedge BUS_CLK);
            if (usb_read && usb_ready) begin
                if (exp_q.size() == 0) begin
                    fail_note("byte consumed with nothing expected");
                end else begin
                    exp = exp_q.pop_front();
                    check_value("usb_data", usb_data, exp);
                end
            end
        end
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge BUS_CLK);
            cycles++;
        end
        $display("error: run did not finish within %0d cycles", MAX_CYCLES);
        $display("errors: %0d", errors + 1);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] w;
        int          pushed;
        int          count;
        int          level;
        logic        flag;
        byte_t       b;

        RST = 1'b1;
        bus_add = '0;
        bus_data_in = '0;
        bus_wr = 1'b0;
        bus_rd = 1'b0;
        usb_read = 1'b0;
        push_en = 1'b0;
        push_data = '0;
        repeat (5) @(posedge BUS_CLK);
        #1;
        RST = 1'b0;
        next_cycle();

        // idle after reset
        check_value("sram_we_b", sram_we_b, 1);
        check_value("sram_oe_b", sram_oe_b, 1);
        check_value("sram_dq_oe", sram_dq_oe, 0);
        check_value("src_read", src_read, 0);
        check_value("usb_ready", usb_ready, 0);
        check_value("fifo_full", fifo_full, 0);
        check_value("fifo_near_full", fifo_near_full, 0);

        // random pushes against random reads
        pushed = 0;
        while (pushed < 30 || exp_q.size() != 0) begin
            r = rand_bits(1);
            if (r[0] && pushed < 30) begin
                w = rand_bits(32);
                queue_word(w);
                pushed++;
            end else begin
                push_en = 1'b0;
            end
            r = rand_bits(1);
            usb_read = r[0];
            next_cycle();
        end
        push_en  = 1'b0;
        usb_read = 1'b0;

        // idle pushes, holder keeps the first half-word
        push_words(8);
        settle();
        read_count(count);
        check_value("fill_count", count, 15);
        check_value("fifo_not_empty", fifo_not_empty, 1);
        drain();

        // overfill, source must stall
        push_words(40);
        while (!fifo_full)
            next_cycle();
        repeat (2) next_cycle();
        level = src_level;
        for (int i = 0; i < 10; i++) begin
            check_value("src_read", src_read, 0);
            check_value("fifo_full", fifo_full, 1);
            next_cycle();
        end
        if (src_level != level || level == 0)
            fail_note("source queue moved while the ring was full");
        drain();

        // read errors, saturating
        soft_reset();
        bus_read(16'd4, b);
        check_value("read_errors", b, 0);
        check_value("fifo_read_error", fifo_read_error, 0);
        for (int i = 1; i <= 5; i++) begin
            if (usb_ready)
                fail_note("usb_ready high with an empty FIFO");
            usb_read = 1'b1;
            next_cycle();
            usb_read = 1'b0;
            bus_read(16'd4, b);
            check_value("read_errors", b, i);
            check_value("fifo_read_error", fifo_read_error, 1);
        end
        usb_read = 1'b1;
        repeat (255) next_cycle();
        usb_read = 1'b0;
        bus_read(16'd4, b);
        check_value("read_errors", b, 255);

        // near-full hysteresis
        bus_write(16'd1, 8'd127);
        bus_write(16'd2, 8'd63);
        push_words(20);
        settle();
        read_count(count);
        check_value("fill_count", count, 39);
        flag = near_full_ref(1'b0, 39, 127, 63);
        check_value("fifo_near_full", fifo_near_full, flag);
        for (int k = 1; k <= 30; k++) begin
            take_byte();
            take_byte();
            while (!usb_ready)
                next_cycle();
            read_count(count);
            check_value("fill_count", count, 39 - k);
            flag = near_full_ref(flag, 39 - k, 127, 63);
            check_value("fifo_near_full", fifo_near_full, flag);
        end
        drain();

        // soft reset restores everything
        push_words(20);
        settle();
        flag = near_full_ref(1'b0, 39, 127, 63);
        check_value("fifo_near_full", fifo_near_full, flag);
        soft_reset();
        read_count(count);
        check_value("fill_count", count, 0);
        bus_read(16'd4, b);
        check_value("read_errors", b, 0);
        check_value("fifo_not_empty", fifo_not_empty, 0);
        check_value("fifo_near_full", fifo_near_full, 0);
        check_value("usb_ready", usb_ready, 0);
        push_words(20);
        settle();
        read_count(count);
        check_value("fill_count", count, 39);
        flag = near_full_ref(1'b0, 39, 242, 12); // default thresholds
        check_value("fifo_near_full", fifo_near_full, flag);
        drain();
        repeat (4) next_cycle();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hdl
hdl/out_fifo_pkg.sv
hdl/fifo_regs.sv
hdl/sram_fifo_ctrl.sv
hdl/usb_byte_out.sv
hdl/fill_level_flags.sv
hdl/out_fifo_top.sv
bench/sram_model.sv
bench/tb_out_fifo.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --timing
TOP        ?= tb_out_fifo
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
